/* src/n64a_defs.svh */
// N64 video front end definitions
`ifndef N64A_DEFS_SVH
`define N64A_DEFS_SVH

// Console bus, widened colour and sync group widths
`define N64A_BUS_W       7
`define N64A_COLOR_W     8
`define N64A_SYNC_W      4

// Fractional bits of the conversion coefficients
`define N64A_COEFF_W     20

// Good pixels in a row before the stream counts as locked
`define N64A_LOCK_PIXELS 8

// Rec. 601 coefficients scaled by 2^20
// Y parts
`define N64A_FYR   20'd313524
`define N64A_FYG   20'd615514
`define N64A_FYB   20'd119538
// Negative Pb parts for R and G, doubled so B enters with weight 1
`define N64A_FPBR  20'd353865
`define N64A_FPBG  20'd694711
// Negative Pr parts for G and B, doubled so R enters with weight 1
`define N64A_FPRG  20'd878052
`define N64A_FPRB  20'd170524

`endif

/* src/n64a_pkg.sv */
// N64 video front end types
`include "n64a_defs.svh"

package n64a_pkg;

  // One word as it appears on the console bus
  typedef logic [`N64A_BUS_W-1:0] bus_t;

  // One widened colour component, also one DAC channel
  typedef logic [`N64A_COLOR_W-1:0] color_t;

  // Sync group, bit 3 down to 0 is nVSYNC, nCLAMP, nHSYNC, nCSYNC
  typedef logic [`N64A_SYNC_W-1:0] sync_t;

  // Good pixel counter, reaches N64A_LOCK_PIXELS without wrapping
  typedef logic [$clog2(`N64A_LOCK_PIXELS+1)-1:0] lock_cnt_t;

  // Word expected on the bus in the current cycle
  // PH_IDLE means a sync word is expected
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_RED,
    PH_GREEN,
    PH_BLUE
  } phase_e;

endpackage

/* src/n64a_phase_fsm.sv */
// Pixel word phase tracker
`timescale 1ns/1ns

module n64a_phase_fsm (
  input  logic vclk_i,
  input  logic nrst_i,
  input  logic ndsync_i,
  output logic cap_sync_o,
  output logic cap_red_o,
  output logic cap_green_o,
  output logic cap_blue_o,
  output logic frame_err_o
);

  n64a_pkg::phase_e state_q;
  n64a_pkg::phase_e state_d;

  // Set for the one cycle right after a blue word
  // A sync word must show up exactly then
  logic sync_due_q;
  logic sync_due_d;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = n64a_pkg::PH_IDLE;
    sync_due_d = 1'b0;
    if (!ndsync_i) begin
      // Sync word restarts the pixel from any state
      state_d = n64a_pkg::PH_RED;
    end else begin
      case (state_q)
        n64a_pkg::PH_RED:   state_d = n64a_pkg::PH_GREEN;
        n64a_pkg::PH_GREEN: state_d = n64a_pkg::PH_BLUE;
        n64a_pkg::PH_BLUE: begin
          state_d    = n64a_pkg::PH_IDLE;
          sync_due_d = 1'b1;
        end
        // Idle without sync just waits
        default:            state_d = n64a_pkg::PH_IDLE;
      endcase
    end
  end

  always_ff @(posedge vclk_i) begin
    if (!nrst_i) begin
      state_q    <= n64a_pkg::PH_IDLE;
      sync_due_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      sync_due_q <= sync_due_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Capture strobes and framing errors
  ////////////////////////////////////////////////////////////

  // Strobes are valid in the cycle the word sits on the bus
  assign cap_sync_o  = !ndsync_i;
  assign cap_red_o   = ndsync_i && (state_q == n64a_pkg::PH_RED);
  assign cap_green_o = ndsync_i && (state_q == n64a_pkg::PH_GREEN);
  assign cap_blue_o  = ndsync_i && (state_q == n64a_pkg::PH_BLUE);

  // Early sync inside a pixel, or missing sync after blue
  assign frame_err_o = (!ndsync_i && ((state_q == n64a_pkg::PH_RED) ||
                                      (state_q == n64a_pkg::PH_GREEN))) ||
                       (ndsync_i && sync_due_q);

endmodule

/* src/n64a_lock_counter.sv */
// Stream lock detector
`timescale 1ns/1ns
`include "n64a_defs.svh"

module n64a_lock_counter (
  input  logic vclk_i,
  input  logic nrst_i,
  input  logic pixel_i,
  input  logic frame_err_i,
  output logic lock_o
);

  // Count where the counter stops and lock is declared
  localparam n64a_pkg::lock_cnt_t lock_max = n64a_pkg::lock_cnt_t'(`N64A_LOCK_PIXELS);

  n64a_pkg::lock_cnt_t cnt_q;
  n64a_pkg::lock_cnt_t cnt_d;

  // Error wins, otherwise count good pixels up to saturation
  always_comb begin
    cnt_d = cnt_q;
    if (frame_err_i) begin
      cnt_d = '0;
    end else if (pixel_i && (cnt_q != lock_max)) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  // Lock follows the next count so it rises on the last good pixel edge
  always_ff @(posedge vclk_i) begin
    if (!nrst_i) begin
      cnt_q  <= '0;
      lock_o <= 1'b0;
    end else begin
      cnt_q  <= cnt_d;
      lock_o <= (cnt_d == lock_max);
    end
  end

endmodule

/* src/n64a_demux.sv */
// Pixel word demultiplexer
`timescale 1ns/1ns

module n64a_demux (
  input  logic              vclk_i,
  input  logic              nrst_i,
  input  n64a_pkg::bus_t    vbus_i,
  input  logic              cap_sync_i,
  input  logic              cap_red_i,
  input  logic              cap_green_i,
  input  logic              cap_blue_i,
  output n64a_pkg::sync_t   sync_o,
  output n64a_pkg::color_t  r_o,
  output n64a_pkg::color_t  g_o,
  output n64a_pkg::color_t  b_o
);

  // Staging for the words that arrive before blue
  n64a_pkg::sync_t sync_q;
  n64a_pkg::bus_t  red_q;
  n64a_pkg::bus_t  green_q;

  // 7 to 8 bit widening, MSB repeated as new LSB
  // 0 stays 0 and 127 becomes 255
  function automatic n64a_pkg::color_t widen(input n64a_pkg::bus_t word);
    widen = {word, word[$bits(n64a_pkg::bus_t)-1]};
  endfunction

  ////////////////////////////////////////////////////////////
  // Staging registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vclk_i) begin
    // Sync group sits in the low bits of the sync word
    if (cap_sync_i) begin
      sync_q <= vbus_i[$bits(n64a_pkg::sync_t)-1:0];
    end
    if (cap_red_i) begin
      red_q <= vbus_i;
    end
    if (cap_green_i) begin
      green_q <= vbus_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pixel output, all channels change on the blue word
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vclk_i) begin
    if (!nrst_i) begin
      sync_o <= '0;
      r_o    <= '0;
      g_o    <= '0;
      b_o    <= '0;
    end else if (cap_blue_i) begin
      sync_o <= sync_q;
      r_o    <= widen(red_q);
      g_o    <= widen(green_q);
      // Blue is taken straight off the bus
      b_o    <= widen(vbus_i);
    end
  end

endmodule

/* src/n64a_vconv.sv */
// RGB to YPbPr colour converter
`timescale 1ns/1ns
`include "n64a_defs.svh"

module n64a_vconv (
  input  logic              vclk_i,
  input  logic              nrst_i,
  input  logic              nen_ypbpr_i,
  input  n64a_pkg::sync_t   sync_i,
  input  n64a_pkg::color_t  r_i,
  input  n64a_pkg::color_t  g_i,
  input  n64a_pkg::color_t  b_i,
  output n64a_pkg::sync_t   sync_o,
  output n64a_pkg::color_t  v1_o,
  output n64a_pkg::color_t  v2_o,
  output n64a_pkg::color_t  v3_o
);

  localparam int color_w = `N64A_COLOR_W;
  localparam int coeff_w = `N64A_COEFF_W;
  // Product of one component and one coefficient
  localparam int prod_w  = color_w + coeff_w;
  // Integer part of a scaled product sits in msb_vo down to lsb_vo
  localparam int msb_vo  = prod_w - 1;
  localparam int lsb_vo  = coeff_w;

  // Stage 1, input delay line, sync rides along with the pipeline
  n64a_pkg::sync_t  s_dly [0:2];
  n64a_pkg::color_t r_dly [0:2];
  n64a_pkg::color_t b_dly [0:2];
  // Green only feeds the products, one stage is enough
  n64a_pkg::color_t g_dly;

  // Stage 2, coefficient products
  logic [prod_w-1:0] r4y_q, g4y_q, b4y_q;
  logic [prod_w-1:0] r4pb_q, g4pb_q;
  logic [prod_w-1:0] g4pr_q, b4pr_q;

  // Stage 3, sums
  // Y coefficients add up to exactly 2^20 so the Y sum cannot exceed prod_w bits
  logic [prod_w-1:0] y_sum_q;
  logic [prod_w:0]   pb_nsum_q;
  logic [prod_w:0]   pr_nsum_q;

  // Output stage arithmetic, one fraction bit kept for rounding
  logic [color_w+1:0] pb_diff;
  logic [color_w+1:0] pr_diff;
  logic [color_w-1:0] y_rnd;
  logic [color_w:0]   pb_rnd;
  logic [color_w:0]   pr_rnd;

  ////////////////////////////////////////////////////////////
  // Pipeline registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vclk_i) begin
    s_dly[0] <= sync_i;
    r_dly[0] <= r_i;
    g_dly    <= g_i;
    b_dly[0] <= b_i;
    for (int i = 1; i < 3; i++) begin
      s_dly[i] <= s_dly[i-1];
      r_dly[i] <= r_dly[i-1];
      b_dly[i] <= b_dly[i-1];
    end

    // Y = 0.299 R + 0.587 G + 0.114 B
    r4y_q  <= `N64A_FYR * r_dly[0];
    g4y_q  <= `N64A_FYG * g_dly;
    b4y_q  <= `N64A_FYB * b_dly[0];
    // Doubled negative parts of Pb and Pr
    r4pb_q <= `N64A_FPBR * r_dly[0];
    g4pb_q <= `N64A_FPBG * g_dly;
    g4pr_q <= `N64A_FPRG * g_dly;
    b4pr_q <= `N64A_FPRB * b_dly[0];

    y_sum_q   <= r4y_q + g4y_q + b4y_q;
    pb_nsum_q <= r4pb_q + g4pb_q;
    pr_nsum_q <= g4pr_q + b4pr_q;
  end

  ////////////////////////////////////////////////////////////
  // Final results
  ////////////////////////////////////////////////////////////

  // Twice Pb and Pr as signed values with one fraction bit
  assign pb_diff = {1'b0, b_dly[2], 1'b0} - pb_nsum_q[msb_vo+1:lsb_vo-1];
  assign pr_diff = {1'b0, r_dly[2], 1'b0} - pr_nsum_q[msb_vo+1:lsb_vo-1];

  // Round on the first fraction bit
  assign y_rnd  = y_sum_q[msb_vo:lsb_vo] + y_sum_q[lsb_vo-1];
  assign pb_rnd = pb_diff[color_w+1:1] + pb_diff[0];
  assign pr_rnd = pr_diff[color_w+1:1] + pr_diff[0];

  // Halving plus 128 offset, done by flipping the sign bit
  always_ff @(posedge vclk_i) begin
    if (!nrst_i) begin
      sync_o <= '0;
      v1_o   <= '0;
      v2_o   <= '0;
      v3_o   <= '0;
    end else if (!nen_ypbpr_i) begin
      sync_o <= s_dly[2];
      v1_o   <= {~pr_rnd[color_w], pr_rnd[color_w-1:1]};
      v2_o   <= y_rnd;
      v3_o   <= {~pb_rnd[color_w], pb_rnd[color_w-1:1]};
    end else begin
      // Bypass, RGB one cycle after the input
      sync_o <= sync_i;
      v1_o   <= r_i;
      v2_o   <= g_i;
      v3_o   <= b_i;
    end
  end

endmodule

/* src/n64a_vout_top.sv */
// N64 video front end top level
`timescale 1ns/1ns

module n64a_vout_top (
  input  logic              vclk_i,
  input  logic              nrst_i,
  input  logic              ndsync_i,
  input  n64a_pkg::bus_t    vbus_i,
  input  logic              nen_ypbpr_i,
  output n64a_pkg::sync_t   sync_o,
  output n64a_pkg::color_t  v1_o,
  output n64a_pkg::color_t  v2_o,
  output n64a_pkg::color_t  v3_o,
  output logic              lock_o
);

  // Capture strobes from the phase tracker
  logic cap_sync;
  logic cap_red;
  logic cap_green;
  logic cap_blue;
  logic frame_err;

  // Assembled pixel, held for four cycles
  n64a_pkg::sync_t  pix_sync;
  n64a_pkg::color_t pix_r;
  n64a_pkg::color_t pix_g;
  n64a_pkg::color_t pix_b;

  n64a_phase_fsm u_phase_fsm (
    .vclk_i      (vclk_i),
    .nrst_i      (nrst_i),
    .ndsync_i    (ndsync_i),
    .cap_sync_o  (cap_sync),
    .cap_red_o   (cap_red),
    .cap_green_o (cap_green),
    .cap_blue_o  (cap_blue),
    .frame_err_o (frame_err)
  );

  // Every blue capture counts as one good pixel
  n64a_lock_counter u_lock_counter (
    .vclk_i      (vclk_i),
    .nrst_i      (nrst_i),
    .pixel_i     (cap_blue),
    .frame_err_i (frame_err),
    .lock_o      (lock_o)
  );

  n64a_demux u_demux (
    .vclk_i      (vclk_i),
    .nrst_i      (nrst_i),
    .vbus_i      (vbus_i),
    .cap_sync_i  (cap_sync),
    .cap_red_i   (cap_red),
    .cap_green_i (cap_green),
    .cap_blue_i  (cap_blue),
    .sync_o      (pix_sync),
    .r_o         (pix_r),
    .g_o         (pix_g),
    .b_o         (pix_b)
  );

  n64a_vconv u_vconv (
    .vclk_i      (vclk_i),
    .nrst_i      (nrst_i),
    .nen_ypbpr_i (nen_ypbpr_i),
    .sync_i      (pix_sync),
    .r_i         (pix_r),
    .g_i         (pix_g),
    .b_i         (pix_b),
    .sync_o      (sync_o),
    .v1_o        (v1_o),
    .v2_o        (v2_o),
    .v3_o        (v3_o)
  );

endmodule

/* verif/n64a_vout_checker.sv */
// Video front end assertion checker
`timescale 1ns/1ns
`include "n64a_defs.svh"

module n64a_vout_checker (
  input logic             vclk_i,
  input logic             nrst_i,
  input logic             ndsync_i,
  input n64a_pkg::bus_t   vbus_i,
  input logic             nen_ypbpr_i,
  input n64a_pkg::sync_t  sync_o,
  input n64a_pkg::color_t v1_o,
  input n64a_pkg::color_t v2_o,
  input n64a_pkg::color_t v3_o,
  input logic             lock_o
);

  // Raised by any failing assertion, polled by the testbench
  logic error_seen = 1'b0;

  // nDSYNC and bus history, bit 0 is one cycle back
  logic [3:0]     dsync_h;
  n64a_pkg::bus_t w1, w2, w3;
  // Blue word seen n+1 cycles back
  logic [4:0]     blue_h;
  logic           blue_now;
  logic           err_now;
  int             cnt_next;
  int             m_cnt;
  logic           m_lock;

  // Model pixel taken at the blue word
  n64a_pkg::sync_t  m_sync;
  n64a_pkg::color_t m_r, m_g, m_b, m_y, m_pb, m_pr;
  // Same YPbPr pixel, lined up with the converter output
  n64a_pkg::sync_t  y_sync;
  n64a_pkg::color_t y_y, y_pb, y_pr;

  // Top bit repeated below the word, 127 maps to 255
  function automatic n64a_pkg::color_t to_color(input n64a_pkg::bus_t w);
    return {w, w[`N64A_BUS_W-1]};
  endfunction

  // Rec. 601 luma, rounded to nearest
  function automatic n64a_pkg::color_t luma(input n64a_pkg::color_t r,
                                            input n64a_pkg::color_t g,
                                            input n64a_pkg::color_t b);
    int acc;
    acc = int'(`N64A_FYR) * int'(r) + int'(`N64A_FYG) * int'(g) + int'(`N64A_FYB) * int'(b);
    return n64a_pkg::color_t'((acc + (1 << (`N64A_COEFF_W - 1))) >>> `N64A_COEFF_W);
  endfunction

  // Own component minus doubled negative parts, halved around 128
  function automatic n64a_pkg::color_t chroma(input n64a_pkg::color_t own,
                                              input int ka, input n64a_pkg::color_t a,
                                              input int kb, input n64a_pkg::color_t b);
    int acc;
    acc = (int'(own) <<< `N64A_COEFF_W) - ka * int'(a) - kb * int'(b);
    acc = 128 + ((acc + (1 << `N64A_COEFF_W)) >>> (`N64A_COEFF_W + 1));
    if (acc > 255) begin
      acc = 255;
    end
    if (acc < 0) begin
      acc = 0;
    end
    return n64a_pkg::color_t'(acc);
  endfunction

  function automatic bit within_one(input n64a_pkg::color_t a, input n64a_pkg::color_t b);
    return (int'(a) - int'(b)) inside {-1, 0, 1};
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Blue follows sync, red and green with no break
  assign blue_now = nrst_i && ndsync_i && dsync_h[0] && dsync_h[1] && !dsync_h[2];
  // Early sync during red or green, or no sync right after blue
  assign err_now  = nrst_i && ((!ndsync_i && !(dsync_h[0] && dsync_h[1])) ||
                               (ndsync_i && (dsync_h[2:0] == 3'b111) && !dsync_h[3]));
  assign cnt_next = err_now ? 0 :
                    ((blue_now && (m_cnt < `N64A_LOCK_PIXELS)) ? m_cnt + 1 : m_cnt);

  always_ff @(posedge vclk_i) begin
    w1 <= vbus_i;
    w2 <= w1;
    w3 <= w2;
    if (!nrst_i) begin
      dsync_h <= '1;
      blue_h  <= '0;
      m_cnt   <= 0;
      m_lock  <= 1'b0;
    end else begin
      dsync_h <= {dsync_h[2:0], ndsync_i};
      blue_h  <= {blue_h[3:0], blue_now};
      m_cnt   <= cnt_next;
      m_lock  <= (cnt_next == `N64A_LOCK_PIXELS);
    end
    if (blue_now) begin
      m_sync <= w3[`N64A_SYNC_W-1:0];
      m_r    <= to_color(w2);
      m_g    <= to_color(w1);
      m_b    <= to_color(vbus_i);
      m_y    <= luma(to_color(w2), to_color(w1), to_color(vbus_i));
      m_pb   <= chroma(to_color(vbus_i), int'(`N64A_FPBR), to_color(w2),
                       int'(`N64A_FPBG), to_color(w1));
      m_pr   <= chroma(to_color(w2), int'(`N64A_FPRG), to_color(w1),
                       int'(`N64A_FPRB), to_color(vbus_i));
    end
    // Converter latency minus one
    if (blue_h[3]) begin
      y_sync <= m_sync;
      y_y    <= m_y;
      y_pb   <= m_pb;
      y_pr   <= m_pr;
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  reset_clear: assert property (@(posedge vclk_i)
    !nrst_i |=> (sync_o == '0) && (v1_o == '0) && (v2_o == '0) && (v3_o == '0) && !lock_o)
  else begin
    $error("[ERROR] reset: expected 0 0 0 0 0, actual %h %h %h %h %b",
           sync_o, v1_o, v2_o, v3_o, lock_o);
    error_seen = 1'b1;
  end

  // RGB passthrough two cycles after blue
  bypass_out: assert property (@(posedge vclk_i) disable iff (!nrst_i)
    blue_h[1] && $past(nen_ypbpr_i) |->
      (sync_o == m_sync) && (v1_o == m_r) && (v2_o == m_g) && (v3_o == m_b))
  else begin
    $error("[ERROR] bypass: expected %h %h %h %h, actual %h %h %h %h",
           m_sync, m_r, m_g, m_b, sync_o, v1_o, v2_o, v3_o);
    error_seen = 1'b1;
  end

  // YPbPr five cycles after blue, Pr on v1 and Pb on v3
  ypbpr_out: assert property (@(posedge vclk_i) disable iff (!nrst_i)
    blue_h[4] && !$past(nen_ypbpr_i) |->
      (sync_o == y_sync) && (v2_o == y_y) && within_one(v1_o, y_pr) && within_one(v3_o, y_pb))
  else begin
    $error("[ERROR] ypbpr: expected %h %h %h %h, actual %h %h %h %h",
           y_sync, y_pr, y_y, y_pb, sync_o, v1_o, v2_o, v3_o);
    error_seen = 1'b1;
  end

  lock_level: assert property (@(posedge vclk_i) disable iff (!nrst_i) lock_o == m_lock)
  else begin
    $error("[ERROR] lock: expected %b, actual %b", m_lock, lock_o);
    error_seen = 1'b1;
  end

  lock_drop: assert property (@(posedge vclk_i) disable iff (!nrst_i) err_now |=> !lock_o)
  else begin
    $error("lock_o still high one cycle after a framing error");
    error_seen = 1'b1;
  end

endmodule

/* verif/n64a_vout_tb.sv */
// Video front end testbench
`timescale 1ns/1ns

module n64a_vout_tb;

  logic             vclk;
  logic             nrst;
  logic             ndsync;
  n64a_pkg::bus_t   vbus;
  logic             nen_ypbpr;
  n64a_pkg::sync_t  sync;
  n64a_pkg::color_t v1;
  n64a_pkg::color_t v2;
  n64a_pkg::color_t v3;
  logic             lock;

  n64a_vout_top dut_i (
    .vclk_i      (vclk),
    .nrst_i      (nrst),
    .ndsync_i    (ndsync),
    .vbus_i      (vbus),
    .nen_ypbpr_i (nen_ypbpr),
    .sync_o      (sync),
    .v1_o        (v1),
    .v2_o        (v2),
    .v3_o        (v3),
    .lock_o      (lock)
  );

  // Assertion checker sits inside the DUT
  bind n64a_vout_top n64a_vout_checker u_checker (.*);

  always #4 vclk = ~vclk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  // One bus word, changed on the falling edge
  task automatic send_word(input logic nds, input n64a_pkg::bus_t word);
    @(negedge vclk);
    ndsync = nds;
    vbus   = word;
  endtask

  // Sync word with spare upper bits set, then R, G, B
  task automatic send_pixel(input n64a_pkg::sync_t s, input n64a_pkg::bus_t r,
                            input n64a_pkg::bus_t g, input n64a_pkg::bus_t b);
    send_word(1'b0, {3'b101, s});
    send_word(1'b1, r);
    send_word(1'b1, g);
    send_word(1'b1, b);
  endtask

  task automatic send_random(input int count);
    for (int i = 0; i < count; i++) begin
      send_pixel(n64a_pkg::sync_t'($urandom), n64a_pkg::bus_t'($urandom),
                 n64a_pkg::bus_t'($urandom), n64a_pkg::bus_t'($urandom));
    end
  endtask

  task automatic wait_lock(input logic level, input int limit);
    int n;
    n = 0;
    while ((lock !== level) && (n < limit)) begin
      @(negedge vclk);
      n++;
    end
    if (lock !== level) begin
      abort_run($sformatf("timeout waiting for lock_o to become %b", level));
    end
  endtask

  // Stop at the first checker failure
  always @(negedge vclk) begin
    if (dut_i.u_checker.error_seen) begin
      abort_run("checker assertion failed");
    end
  end

  initial begin
    vclk      = 1'b0;
    nrst      = 1'b0;
    ndsync    = 1'b1;
    vbus      = '0;
    nen_ypbpr = 1'b1;
    void'($urandom(51116));
    repeat (2) @(negedge vclk);
    nrst = 1'b1;

    // Bypass with extreme words while lock builds over 8 pixels
    send_pixel(4'hf, 7'd127, 7'd127, 7'd127);
    send_pixel(4'h0, 7'd0, 7'd0, 7'd0);
    send_pixel(4'h5, 7'd127, 7'd0, 7'd127);
    send_random(5);
    wait_lock(1'b1, 4);
    send_random(8);

    // YPbPr, gray first so Pb and Pr sit at 128
    nen_ypbpr = 1'b0;
    send_pixel(4'ha, 7'd64, 7'd64, 7'd64);
    send_random(24);

    // Sync lands in the green slot, then 8 good pixels relock
    send_word(1'b0, 7'h5a);
    send_word(1'b1, 7'h11);
    send_random(1);
    wait_lock(1'b0, 4);
    send_random(7);
    wait_lock(1'b1, 4);
    send_random(2);
    // Let the last pixel clear the converter pipeline
    repeat (6) @(negedge vclk);

    if (dut_i.u_checker.error_seen) begin
      abort_run("checker assertion failed");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* filelist.f */
+incdir+src
src/n64a_pkg.sv
src/n64a_phase_fsm.sv
src/n64a_lock_counter.sv
src/n64a_demux.sv
src/n64a_vconv.sv
src/n64a_vout_top.sv
verif/n64a_vout_checker.sv
verif/n64a_vout_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= n64a_vout_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
RUN_ARGS  ?= +verilator+error+limit+10

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "all tests passed" $(LOG) || (echo "no pass report in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
